//--- all.f
hw/dbg_capture_pkg.sv
hw/mask_table.sv
hw/addr_matcher.sv
hw/capture_ctrl.sv
hw/sample_counter.sv
hw/capture_buffer.sv
hw/dbg_capture_top.sv
dv/clk_gen.sv
dv/tb_dbg_capture.sv

//--- dv/clk_gen.sv
`default_nettype none

module clk_gen (
  output logic clk,
  output logic arst_n
);

  localparam int PERIOD     = 40;
  localparam int RST_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/tb_dbg_capture.sv
`default_nettype none

module tb_dbg_capture;

  import dbg_capture_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 5;

  typedef enum logic [3:0] {
    OP_MASK, OP_ARM, OP_DISARM, OP_ARM_DISARM, OP_BUS, OP_IDLE, OP_READ, OP_COUNT, OP_STATE
  } op_t;

  // One clock cycle of stimulus
  typedef struct packed {
    op_t         op;
    logic [4:0]  idx;
    mask_entry_t entry;
    bus_sample_t sample;
    cap_state_t  exp_state;
  } step_t;

  logic                 clk;
  logic                 arst_n;
  logic                 mask_wr;
  logic [MASK_ID_W-1:0] mask_id;
  mask_entry_t          mask_entry;
  logic                 arm;
  logic                 disarm;
  logic                 bus_valid;
  bus_sample_t          bus;
  logic [CAP_IDX_W-1:0] rd_index;
  capture_rec_t         rd_rec;
  cap_state_t           state;
  logic [CNT_W-1:0]     count;

  step_t        steps[$];
  logic [31:0]  rng;
  int           errors;
  bit           table_ready;
  bit           rd_pending;
  capture_rec_t rd_exp;

  // Reference model state
  mask_entry_t  m_tab [MASK_N];
  logic         m_hit;
  capture_rec_t m_hit_rec;
  cap_state_t   m_state;
  int           m_count;
  capture_rec_t m_mem [CAP_DEPTH];

  clk_gen u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  dbg_capture_top dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .mask_wr    (mask_wr),
    .mask_id    (mask_id),
    .mask_entry (mask_entry),
    .arm        (arm),
    .disarm     (disarm),
    .bus_valid  (bus_valid),
    .bus        (bus),
    .rd_index   (rd_index),
    .rd_rec     (rd_rec),
    .state      (state),
    .count      (count)
  );

  // ************************************************************************
  // Compare tasks
  // ************************************************************************

  task automatic check_rec(string name, capture_rec_t exp, capture_rec_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      $display("Checks failed");
      $fatal(1, "Record mismatch on %s", name);
    end
  endtask

  task automatic check_count(string name, logic [CNT_W-1:0] exp, logic [CNT_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
      $display("Checks failed");
      $fatal(1, "Count mismatch on %s", name);
    end
  endtask

  task automatic check_state(string name, cap_state_t exp, cap_state_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      $display("Checks failed");
      $fatal(1, "State mismatch on %s", name);
    end
  endtask

  // ************************************************************************
  // Reference model
  // ************************************************************************

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Enabled lanes must hold equal bytes, no lane enabled means no match
  function automatic bit entry_matches(mask_entry_t e, logic [ADDR_W-1:0] addr);
    bit ok;
    ok = (e.lane_en != '0);
    for (int l = 0; l < LANE_N; l++) begin
      if (e.lane_en[l] && (e.addr[8*l +: 8] != addr[8*l +: 8])) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  function automatic int find_winner(logic [ADDR_W-1:0] addr);
    for (int i = 0; i < MASK_N; i++) begin
      if (entry_matches(m_tab[i], addr)) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Advances the model over one rising edge with the inputs as driven
  task automatic model_cycle();
    int         win;
    cap_state_t nxt_state;
    int         nxt_count;
    nxt_state = m_state;
    nxt_count = m_count;
    if (disarm) begin
      nxt_state = CAP_IDLE;
    end else if (arm) begin
      nxt_state = CAP_ARMED;
      nxt_count = 0;
    end else if (m_state == CAP_ARMED && m_count == CAP_DEPTH) begin
      nxt_state = CAP_FULL;
    end else if (m_state == CAP_ARMED && m_hit) begin
      m_mem[m_count] = m_hit_rec;
      nxt_count = m_count + 1;
    end
    // Sample sees the table as it stood before this edge
    win = find_winner(bus.addr);
    m_hit = bus_valid && (win >= 0);
    if (bus_valid) begin
      m_hit_rec.addr     = bus.addr;
      m_hit_rec.data     = bus.data;
      m_hit_rec.is_write = bus.is_write;
      m_hit_rec.mask_id  = (win < 0) ? '0 : MASK_ID_W'(win);
    end
    if (mask_wr) begin
      m_tab[mask_id] = mask_entry;
    end
    m_state = nxt_state;
    m_count = nxt_count;
  endtask

  // ************************************************************************
  // Stimulus table
  // ************************************************************************

  task automatic push_step(op_t op, int idx, mask_entry_t e, bus_sample_t s, cap_state_t st);
    step_t v;
    v.op        = op;
    v.idx       = 5'(idx);
    v.entry     = e;
    v.sample    = s;
    v.exp_state = st;
    steps.push_back(v);
  endtask

  task automatic host_op(op_t op);
    push_step(op, 0, '0, '0, CAP_IDLE);
  endtask

  task automatic program_mask(int id, logic [3:0] lane_en, logic [31:0] addr);
    push_step(OP_MASK, id, '{lane_en: lane_en, addr: addr}, '0, CAP_IDLE);
  endtask

  task automatic issue_bus(logic [31:0] addr, logic [31:0] data, logic wr);
    push_step(OP_BUS, 0, '0, '{addr: addr, data: data, is_write: wr}, CAP_IDLE);
  endtask

  // Top byte fixed so entry 12 takes every cycle
  task automatic random_bus(int n);
    logic [31:0] addr;
    repeat (n) begin
      rng  = xorshift32(rng);
      addr = {8'hA5, rng[23:0]};
      rng  = xorshift32(rng);
      issue_bus(addr, rng, rng[0]);
    end
  endtask

  task automatic idle_for(int n);
    repeat (n) host_op(OP_IDLE);
  endtask

  task automatic read_range(int first, int last);
    for (int i = first; i <= last; i++) begin
      push_step(OP_READ, i, '0, '0, CAP_IDLE);
    end
    idle_for(1);
  endtask

  task automatic state_point(cap_state_t st);
    push_step(OP_STATE, 0, '0, '0, st);
  endtask

  task automatic build_table();
    // Reset values, then an empty table captures nothing
    state_point(CAP_IDLE);
    host_op(OP_COUNT);
    host_op(OP_ARM);
    issue_bus(32'h0000_0000, 32'h1111_1111, 1'b1);
    issue_bus(32'hDEAD_BEEF, 32'h2222_2222, 1'b0);
    idle_for(2);
    host_op(OP_COUNT);
    state_point(CAP_ARMED);
    // Byte-lane masking
    program_mask(5, 4'b0011, 32'h0000_1234);
    program_mask(6, 4'b1100, 32'hBEEF_0000);
    host_op(OP_ARM);
    issue_bus(32'hFFFF_1234, 32'hCAFE_0001, 1'b1);
    issue_bus(32'h1111_1234, 32'hCAFE_0002, 1'b0);
    issue_bus(32'h0000_1235, 32'hCAFE_0003, 1'b1);
    issue_bus(32'hBEEF_7777, 32'hCAFE_0004, 1'b0);
    issue_bus(32'hBEEE_0000, 32'hCAFE_0005, 1'b1);
    idle_for(2);
    host_op(OP_COUNT);
    read_range(0, 2);
    // Priority, then the same cycle after entry 3 is disabled
    program_mask(3, 4'b0001, 32'h0000_00C3);
    program_mask(9, 4'b0011, 32'h0000_44C3);
    host_op(OP_ARM);
    issue_bus(32'h1234_44C3, 32'h3333_0003, 1'b1);
    program_mask(3, 4'b0000, 32'h0000_0000);
    issue_bus(32'h1234_44C3, 32'h9999_0009, 1'b0);
    idle_for(2);
    host_op(OP_COUNT);
    read_range(0, 1);
    // Back-to-back random cycles
    program_mask(12, 4'b1000, 32'hA500_0000);
    host_op(OP_ARM);
    random_bus(20);
    idle_for(2);
    host_op(OP_COUNT);
    state_point(CAP_ARMED);
    read_range(0, 19);
    // Fill the buffer, later hits must not disturb it
    random_bus(14);
    idle_for(3);
    host_op(OP_COUNT);
    state_point(CAP_FULL);
    random_bus(3);
    idle_for(3);
    host_op(OP_COUNT);
    state_point(CAP_FULL);
    read_range(0, 31);
    // Arm and disarm
    host_op(OP_ARM);
    random_bus(2);
    idle_for(2);
    host_op(OP_COUNT);
    host_op(OP_DISARM);
    random_bus(2);
    idle_for(2);
    host_op(OP_COUNT);
    state_point(CAP_IDLE);
    host_op(OP_ARM);
    state_point(CAP_ARMED);
    host_op(OP_COUNT);
    issue_bus(32'hA500_0077, 32'h7777_0077, 1'b1);
    idle_for(2);
    host_op(OP_COUNT);
    read_range(0, 0);
    host_op(OP_ARM_DISARM);
    state_point(CAP_IDLE);
    host_op(OP_COUNT);
    issue_bus(32'hA500_0088, 32'h8888_0088, 1'b0);
    idle_for(2);
    host_op(OP_COUNT);
    state_point(CAP_IDLE);
  endtask

  // ************************************************************************
  // Step driver
  // ************************************************************************

  task automatic drive_step(step_t s);
    @(negedge clk);
    if (rd_pending) begin
      check_rec("rd_rec", rd_exp, rd_rec);
      rd_pending = 1'b0;
    end
    mask_wr   = 1'b0;
    arm       = 1'b0;
    disarm    = 1'b0;
    bus_valid = 1'b0;
    case (s.op)
      OP_MASK: begin
        mask_wr    = 1'b1;
        mask_id    = s.idx[MASK_ID_W-1:0];
        mask_entry = s.entry;
      end
      OP_ARM:        arm = 1'b1;
      OP_DISARM:     disarm = 1'b1;
      OP_ARM_DISARM: begin
        arm    = 1'b1;
        disarm = 1'b1;
      end
      OP_BUS: begin
        bus_valid = 1'b1;
        bus       = s.sample;
      end
      // Read data returns after the next rising edge
      OP_READ: begin
        rd_index   = s.idx;
        rd_exp     = m_mem[s.idx];
        rd_pending = 1'b1;
      end
      OP_COUNT: check_count("count", CNT_W'(m_count), count);
      OP_STATE: check_state("state", s.exp_state, state);
      default: begin
      end
    endcase
    model_cycle();
  endtask

  initial begin
    mask_wr    = 1'b0;
    mask_id    = '0;
    mask_entry = '0;
    arm        = 1'b0;
    disarm     = 1'b0;
    bus_valid  = 1'b0;
    bus        = '0;
    rd_index   = '0;
    errors     = 0;
    rd_pending = 1'b0;
    rng        = 32'h181d;
    m_hit      = 1'b0;
    m_hit_rec  = '0;
    m_state    = CAP_IDLE;
    m_count    = 0;
    foreach (m_tab[i]) m_tab[i] = '0;
    build_table();
    table_ready = 1'b1;
    wait (arst_n === 1'b1);
    foreach (steps[i]) drive_step(steps[i]);
    @(negedge clk);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Ten cycles per table step is far beyond what any step needs
  initial begin
    wait (table_ready);
    #((RST_CYCLES + steps.size() * 10) * CLK_PERIOD);
    $display("Timeout: the stimulus table did not complete in time");
    $display("Checks failed");
    $fatal(1, "Run stopped by the watchdog");
  end

endmodule

`default_nettype wire

//--- hw/addr_matcher.sv
`default_nettype none

module addr_matcher (
  input  logic                                                  clk,
  input  logic                                                  arst_n,
  input  logic                                                  bus_valid,
  input  dbg_capture_pkg::bus_sample_t                          bus,
  input  dbg_capture_pkg::mask_entry_t [dbg_capture_pkg::MASK_N-1:0] entries,
  output logic                                                  hit,
  output dbg_capture_pkg::capture_rec_t                         hit_rec
);

  import dbg_capture_pkg::*;

  logic [MASK_N-1:0]    match;
  logic [MASK_ID_W-1:0] win_id;

  // ************************************************************************
  // Per-entry byte-lane compare
  // ************************************************************************

  for (genvar i = 0; i < MASK_N; i++) begin : g_entry
    logic [LANE_N-1:0] lane_ok;

    // Disabled lane always passes
    for (genvar l = 0; l < LANE_N; l++) begin : g_lane
      assign lane_ok[l] = ~entries[i].lane_en[l] |
                          (entries[i].addr[LANE_W*l +: LANE_W] == bus.addr[LANE_W*l +: LANE_W]);
    end

    // At least one lane must be enabled
    assign match[i] = (|entries[i].lane_en) & (&lane_ok);
  end

  // Lowest index wins
  always_comb begin
    win_id = '0;
    for (int i = MASK_N - 1; i >= 0; i--) begin
      if (match[i]) begin
        win_id = MASK_ID_W'(i);
      end
    end
  end

  // ************************************************************************
  // Output stage
  // ************************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hit <= 1'b0;
    end else begin
      hit <= bus_valid & (|match);
    end
  end

  always_ff @(posedge clk) begin
    if (bus_valid) begin
      hit_rec <= '{addr: bus.addr, data: bus.data, is_write: bus.is_write, mask_id: win_id};
    end
  end

endmodule

`default_nettype wire

//--- hw/capture_buffer.sv
`default_nettype none

module capture_buffer (
  input  logic                                  clk,
  input  logic                                  wr_en,
  input  logic [dbg_capture_pkg::CAP_IDX_W-1:0] wr_index,
  input  dbg_capture_pkg::capture_rec_t         wr_rec,
  input  logic [dbg_capture_pkg::CAP_IDX_W-1:0] rd_index,
  output dbg_capture_pkg::capture_rec_t         rd_rec
);

  import dbg_capture_pkg::*;

  capture_rec_t mem [CAP_DEPTH];

  // ************************************************************************
  // Write port, capture side
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_rec;
    end
  end

  // ************************************************************************
  // Read port, host side
  // ************************************************************************

  // One cycle read latency
  always_ff @(posedge clk) begin
    rd_rec <= mem[rd_index];
  end

endmodule

`default_nettype wire

//--- hw/capture_ctrl.sv
`default_nettype none

module capture_ctrl (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        arm,
  input  logic                        disarm,
  input  logic                        hit,
  input  logic                        full,
  output logic                        cnt_clr,
  output logic                        cnt_inc,
  output logic                        wr_en,
  output dbg_capture_pkg::cap_state_t state
);

  import dbg_capture_pkg::*;

  cap_state_t state_nxt;

  // ************************************************************************
  // State register
  // ************************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= CAP_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ************************************************************************
  // Next state and capture strobes
  // ************************************************************************

  always_comb begin
    state_nxt = state;
    cnt_clr   = 1'b0;
    cnt_inc   = 1'b0;
    wr_en     = 1'b0;

    if (disarm) begin
      // Disarm beats arm, count is kept for readback
      state_nxt = CAP_IDLE;
    end else if (arm) begin
      // Rearm from any state restarts at index 0
      state_nxt = CAP_ARMED;
      cnt_clr   = 1'b1;
    end else begin
      case (state)
        CAP_ARMED: begin
          if (full) begin
            state_nxt = CAP_FULL;
          end else if (hit) begin
            wr_en   = 1'b1;
            cnt_inc = 1'b1;
          end
        end
        // Idle and full drop hits
        default: begin
          state_nxt = state;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dbg_capture_pkg.sv
`default_nettype none

package dbg_capture_pkg;

  // ************************************************************************
  // Sizes
  // ************************************************************************

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int LANE_N    = 4;
  // Bits per byte lane of the address compare
  localparam int LANE_W    = ADDR_W / LANE_N;
  localparam int MASK_N    = 16;
  localparam int MASK_ID_W = 4;
  localparam int CAP_DEPTH = 32;
  localparam int CAP_IDX_W = 5;
  // Count runs 0 to CAP_DEPTH inclusive
  localparam int CNT_W     = 6;

  // ************************************************************************
  // Types
  // ************************************************************************

  // One compare entry, all lanes clear means disabled
  typedef struct packed {
    logic [LANE_N-1:0] lane_en;
    logic [ADDR_W-1:0] addr;
  } mask_entry_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              is_write;
  } bus_sample_t;

  typedef struct packed {
    logic [ADDR_W-1:0]    addr;
    logic [DATA_W-1:0]    data;
    logic                 is_write;
    logic [MASK_ID_W-1:0] mask_id;
  } capture_rec_t;

  typedef enum logic [1:0] {
    CAP_IDLE  = 2'd0,
    CAP_ARMED = 2'd1,
    CAP_FULL  = 2'd2
  } cap_state_t;

endpackage

`default_nettype wire

//--- hw/dbg_capture_top.sv
`default_nettype none

module dbg_capture_top (
  input  logic                                  clk,
  input  logic                                  arst_n,
  // Host mask programming
  input  logic                                  mask_wr,
  input  logic [dbg_capture_pkg::MASK_ID_W-1:0] mask_id,
  input  dbg_capture_pkg::mask_entry_t          mask_entry,
  // Host control
  input  logic                                  arm,
  input  logic                                  disarm,
  // Monitored bus
  input  logic                                  bus_valid,
  input  dbg_capture_pkg::bus_sample_t          bus,
  // Host readback and status
  input  logic [dbg_capture_pkg::CAP_IDX_W-1:0] rd_index,
  output dbg_capture_pkg::capture_rec_t         rd_rec,
  output dbg_capture_pkg::cap_state_t           state,
  output logic [dbg_capture_pkg::CNT_W-1:0]     count
);

  import dbg_capture_pkg::*;

  mask_entry_t [MASK_N-1:0] entries;
  logic                     hit;
  capture_rec_t             hit_rec;
  logic                     cnt_clr;
  logic                     cnt_inc;
  logic                     wr_en;
  logic                     full;

  mask_table u_mask_table (
    .clk        (clk),
    .arst_n     (arst_n),
    .mask_wr    (mask_wr),
    .mask_id    (mask_id),
    .mask_entry (mask_entry),
    .entries    (entries)
  );

  addr_matcher u_addr_matcher (
    .clk       (clk),
    .arst_n    (arst_n),
    .bus_valid (bus_valid),
    .bus       (bus),
    .entries   (entries),
    .hit       (hit),
    .hit_rec   (hit_rec)
  );

  capture_ctrl u_capture_ctrl (
    .clk     (clk),
    .arst_n  (arst_n),
    .arm     (arm),
    .disarm  (disarm),
    .hit     (hit),
    .full    (full),
    .cnt_clr (cnt_clr),
    .cnt_inc (cnt_inc),
    .wr_en   (wr_en),
    .state   (state)
  );

  sample_counter u_sample_counter (
    .clk     (clk),
    .arst_n  (arst_n),
    .cnt_clr (cnt_clr),
    .cnt_inc (cnt_inc),
    .count   (count),
    .full    (full)
  );

  // Next free slot is the current count
  capture_buffer u_capture_buffer (
    .clk      (clk),
    .wr_en    (wr_en),
    .wr_index (count[CAP_IDX_W-1:0]),
    .wr_rec   (hit_rec),
    .rd_index (rd_index),
    .rd_rec   (rd_rec)
  );

endmodule

`default_nettype wire

//--- hw/mask_table.sv
`default_nettype none

module mask_table (
  input  logic                                                  clk,
  input  logic                                                  arst_n,
  input  logic                                                  mask_wr,
  input  logic [dbg_capture_pkg::MASK_ID_W-1:0]                 mask_id,
  input  dbg_capture_pkg::mask_entry_t                          mask_entry,
  output dbg_capture_pkg::mask_entry_t [dbg_capture_pkg::MASK_N-1:0] entries
);

  // ************************************************************************
  // Entry bank
  // ************************************************************************

  // Host writes one entry per strobe, selected by mask_id.
  // Reset leaves every entry with all lane enables clear,
  // so nothing matches until the host programs the table.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      entries <= '0;
    end else if (mask_wr) begin
      entries[mask_id] <= mask_entry;
    end
  end

endmodule

`default_nettype wire

//--- hw/sample_counter.sv
`default_nettype none

module sample_counter (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              cnt_clr,
  input  logic                              cnt_inc,
  output logic [dbg_capture_pkg::CNT_W-1:0] count,
  output logic                              full
);

  import dbg_capture_pkg::*;

  // Buffer is full once every record slot holds a capture
  assign full = (count == CNT_W'(CAP_DEPTH));

  // Clear has priority, count holds at the top
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (cnt_clr) begin
      count <= '0;
    end else if (cnt_inc && !full) begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire
